/* verilog.f */
alu_pkg.sv
alu_op_if.sv
alu_res_if.sv
operand_capture.sv
arith_unit.sv
logic_unit.sv
result_stage.sv
alu_top.sv
tb_alu.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then look for the fail message in the log
verilator --binary --timing -Wno-fatal --top-module tb_alu -f verilog.f > build.log 2>&1 \
  && ./obj_dir/Vtb_alu > sim.log 2>&1 \
  || { cat build.log; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && exit 1 || exit 0

/* tb_alu.sv */
`timescale 1ns/1ps

module tb_alu;
  import alu_pkg::*;

  localparam int W     = 8;                  // Operand width
  localparam int TMO   = 16;                 // Wait window of the capture stage
  localparam int SH    = $clog2(W);          // Rotate amount bits
  localparam int REPS  = 2;                  // Random ops per command code
  localparam int N_OPS = 2 * 16 * REPS + 3 + 4 + 3 + 2 + 1;
  localparam int LIMIT = 40 * N_OPS + 200;   // Cycle budget for the whole run
  localparam int EXP_W = W + 7;              // RES plus six flags

  logic             CLK;
  logic             RST;
  logic             CE;
  logic             MODE;
  logic             CIN;
  logic [3:0]       CMD;
  logic [1:0]       INP_VALID;
  logic [W-1:0]     OPA;
  logic [W-1:0]     OPB;
  logic [W:0]       RES;
  logic             COUT;
  logic             OFLOW;
  logic             G;
  logic             E;
  logic             L;
  logic             ERR;
  logic             RES_VALID;
  logic [EXP_W-1:0] exp_q[$];                // Expected words in issue order
  logic [EXP_W-1:0] exp_v;
  logic [15:0]      lfsr;
  logic [W-1:0]     ra;                      // Current random operands
  logic [W-1:0]     rb;
  logic             rc;
  logic [W-1:0]     hold_a;
  int               cycles = 0;
  int               checks = 0;
  int               errors = 0;
  int               test_err0 = 0;           // Error count at test start

  alu_top #(.OPERAND_WIDTH(W), .TIMEOUT_CYCLES(TMO)) DUT (
    .CLK(CLK), .RST(RST), .CE(CE), .MODE(MODE), .CIN(CIN), .CMD(CMD),
    .INP_VALID(INP_VALID), .OPA(OPA), .OPB(OPB), .RES(RES), .COUT(COUT),
    .OFLOW(OFLOW), .G(G), .E(E), .L(L), .ERR(ERR), .RES_VALID(RES_VALID)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;                  // 20 ns period
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // Taps 16 14 13 11
  endfunction

  // One LFSR step per bit taken
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[14:0], lfsr[0]};
    end
    return v;
  endfunction

  // Expected {RES, COUT, OFLOW, G, E, L, ERR}
  function automatic logic [EXP_W-1:0] alu_model(input logic mode, input logic [3:0] cmd,
                                                 input logic [W-1:0] a, input logic [W-1:0] b,
                                                 input logic cin, input logic tmo);
    logic [W:0]    za;
    logic [W:0]    zb;
    logic [W:0]    r;
    logic [W-1:0]  v;
    logic [SH-1:0] amt;
    logic          co;
    logic          ov;
    logic          g;
    logic          e;
    logic          l;
    logic          er;
    za  = {1'b0, a};
    zb  = {1'b0, b};
    r   = '0;
    v   = '0;
    co  = 1'b0;
    ov  = 1'b0;
    g   = 1'b0;
    e   = 1'b0;
    l   = 1'b0;
    er  = 1'b0;
    amt = b[SH-1:0];
    if (tmo) begin
      er = 1'b1;                             // Error word only
    end else if (mode) begin
      case (cmd)
        ADD:     r = za + zb;
        SUB:     r = za - zb;
        ADC:     r = za + zb + {{W{1'b0}}, cin};
        SBB:     r = za - zb - {{W{1'b0}}, cin};
        INC_A:   r = za + {{W{1'b0}}, 1'b1};
        DEC_A:   r = za - {{W{1'b0}}, 1'b1};
        INC_B:   r = zb + {{W{1'b0}}, 1'b1};
        DEC_B:   r = zb - {{W{1'b0}}, 1'b1};
        CMP:     r = '0;
        SADD:    r = {a[W-1], a} + {b[W-1], b};
        SSUB:    r = {a[W-1], a} - {b[W-1], b};
        default: er = 1'b1;
      endcase
      if (cmd inside {ADD, ADC, INC_A, INC_B, SADD}) co = r[W];  // Carry out of bit W-1
      if (cmd inside {SUB, SBB, DEC_A, DEC_B}) ov = r[W];        // Borrow wraps into bit W
      if (cmd == SADD) ov = (a[W-1] == b[W-1]) && (r[W-1] != a[W-1]);
      if (cmd == SSUB) ov = (a[W-1] != b[W-1]) && (r[W-1] != a[W-1]);
      if (cmd == CMP) begin
        e = a == b;
        g = a > b;
        l = a < b;
      end
      if (cmd inside {SADD, SSUB}) begin     // Two's complement compare
        e = a == b;
        g = $signed(a) > $signed(b);
        l = $signed(a) < $signed(b);
      end
    end else begin
      case (cmd)
        AND:     v = a & b;
        NAND:    v = ~(a & b);
        OR:      v = a | b;
        NOR:     v = ~(a | b);
        XOR:     v = a ^ b;
        XNOR:    v = ~(a ^ b);
        NOT_A:   v = ~a;
        NOT_B:   v = ~b;
        SHR_A:   v = a >> 1;
        SHL_A:   v = a << 1;
        SHR_B:   v = b >> 1;
        SHL_B:   v = b << 1;
        ROL:     v = (a << amt) | (a >> (W - amt));
        ROR:     v = (a >> amt) | (a << (W - amt));
        default: er = 1'b1;
      endcase
      r = {1'b0, v};
      if ((cmd == ROL || cmd == ROR) && |b[W-1:SH]) er = 1'b1;  // Amount out of range
    end
    return {r, co, ov, g, e, l, er};
  endfunction

  task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_outputs(input logic [EXP_W-1:0] x);
    check_val("RES", 16'(RES), 16'(x[EXP_W-1:6]));
    check_val("COUT", 16'(COUT), 16'(x[5]));
    check_val("OFLOW", 16'(OFLOW), 16'(x[4]));
    check_val("G", 16'(G), 16'(x[3]));
    check_val("E", 16'(E), 16'(x[2]));
    check_val("L", 16'(L), 16'(x[1]));
    check_val("ERR", 16'(ERR), 16'(x[0]));
  endtask

  // Outputs are settled at the falling edge
  always @(negedge CLK) begin
    if (!RST && RES_VALID) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("RES_VALID came with no result expected at cycle %0d", cycles);
      end else begin
        exp_v = exp_q.pop_front();
        check_outputs(exp_v);
      end
    end
  end

  always @(posedge CLK) begin
    cycles++;
    if (cycles > LIMIT) begin                // DUT stopped answering
      $display("run stopped after %0d cycles without finishing", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  task automatic drive(input logic ce, input logic m, input logic [3:0] c,
                       input logic [W-1:0] a, input logic [W-1:0] b,
                       input logic ci, input logic [1:0] v);
    @(posedge CLK);
    CE        <= ce;
    MODE      <= m;
    CMD       <= c;
    OPA       <= a;
    OPB       <= b;
    CIN       <= ci;
    INP_VALID <= v;
  endtask

  task automatic send_pair(input logic m, input logic [3:0] c, input logic [W-1:0] a,
                           input logic [W-1:0] b, input logic ci);
    drive(1'b1, m, c, a, b, ci, 2'b11);
    exp_q.push_back(alu_model(m, c, a, b, ci, 1'b0));
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge CLK);
      CE        <= 1'b1;
      INP_VALID <= 2'b00;
    end
  endtask

  task automatic pick;
    ra = W'(rand_bits(W));
    rb = W'(rand_bits(W));
    rc = rand_bits(1) != 16'd0;
  endtask

  // One operand that may be rewritten and the other after short gaps
  task automatic stagger(input logic [1:0] first, input logic overwrite);
    logic [W-1:0] a;
    logic [W-1:0] b;
    logic [3:0]   c;
    logic         m;
    pick();
    a = ra;
    b = rb;
    drive(1'b1, 1'b0, XOR, ra, rb, 1'b0, first);
    idle(1 + int'(rand_bits(3)));
    if (overwrite) begin
      pick();
      if (first[0]) a = ra;
      else b = rb;
      drive(1'b1, 1'b1, SUB, ra, rb, 1'b1, first);
      idle(1 + int'(rand_bits(3)));
    end
    pick();
    m = rand_bits(1) != 16'd0;
    c = 4'(rand_bits(4));
    if (first[0]) b = rb;
    else a = ra;
    drive(1'b1, m, c, ra, rb, rc, ~first);   // Last capture sets the command
    exp_q.push_back(alu_model(m, c, a, b, rc, 1'b0));
  endtask

  task automatic end_test(input string name);
    idle(1);
    for (int i = 0; i < 8 && exp_q.size() != 0; i++) begin
      idle(1);
    end
    if (exp_q.size() != 0) begin
      $display("%0d expected results never appeared in test %s", exp_q.size(), name);
      errors += exp_q.size();
      exp_q.delete();
    end
    $display("test %s done, %0d errors", name, errors - test_err0);
    test_err0 = errors;
  endtask

  initial begin
    lfsr      = 16'd36;
    RST       = 1'b1;
    CE        = 1'b0;
    MODE      = 1'b0;
    CIN       = 1'b0;
    CMD       = 4'h0;
    INP_VALID = 2'b00;
    OPA       = '0;
    OPB       = '0;
    repeat (5) @(posedge CLK);
    RST <= 1'b0;
    idle(3);
    @(negedge CLK);
    check_val("RES_VALID", 16'(RES_VALID), 16'h0);
    check_outputs('0);
    end_test("reset");
    for (int c = 0; c < 16; c++) begin       // Pairs back to back at one per edge
      repeat (REPS) begin
        pick();
        send_pair(1'b1, 4'(c), ra, rb, rc);
      end
    end
    send_pair(1'b1, SADD, 8'h7f, 8'h01, 1'b0);  // Positive overflow
    send_pair(1'b1, SSUB, 8'h80, 8'h01, 1'b0);  // Negative overflow
    send_pair(1'b1, CMP, 8'h5a, 8'h5a, 1'b0);
    end_test("arith");
    for (int c = 0; c < 16; c++) begin
      repeat (REPS) begin
        pick();
        send_pair(1'b0, 4'(c), ra, rb, rc);
      end
    end
    send_pair(1'b0, ROL, 8'hb4, 8'h03, 1'b0);
    send_pair(1'b0, ROL, 8'hb4, 8'h13, 1'b0);   // ERR while RES is still rotated
    send_pair(1'b0, ROR, 8'h2d, 8'h05, 1'b0);
    send_pair(1'b0, ROR, 8'h2d, 8'h85, 1'b0);
    end_test("logic");
    stagger(2'b01, 1'b0);
    stagger(2'b10, 1'b0);
    stagger(2'b01, 1'b1);
    end_test("stagger");
    pick();
    drive(1'b1, 1'b1, ADD, ra, rb, rc, 2'b10);  // Lone B that is never completed
    exp_q.push_back(alu_model(1'b0, 4'h0, '0, '0, 1'b0, 1'b1));
    idle(TMO + 4);
    pick();
    send_pair(1'b1, ADD, ra, rb, rc);
    end_test("timeout");
    pick();
    drive(1'b0, 1'b1, ADD, ra, rb, rc, 2'b11);  // Ignored with nothing held
    idle(3);
    pick();
    hold_a = ra;
    drive(1'b1, 1'b0, OR, ra, rb, 1'b0, 2'b01);
    repeat (3) begin
      pick();
      drive(1'b0, 1'b1, SUB, ra, rb, rc, 2'b11);
    end
    pick();
    drive(1'b1, 1'b0, XNOR, ra, rb, 1'b0, 2'b10);
    exp_q.push_back(alu_model(1'b0, XNOR, hold_a, rb, 1'b0, 1'b0));
    end_test("ce_low");
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* alu_top.sv */
`timescale 1ns/1ps

module alu_top #(
  parameter int OPERAND_WIDTH  = 8,
  parameter int TIMEOUT_CYCLES = 16
) (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      CE,
  input  logic                      MODE,        // High for arithmetic
  input  logic                      CIN,
  input  logic [alu_pkg::CMD_W-1:0] CMD,
  input  logic [1:0]                INP_VALID,   // Bit 0 for OPA, bit 1 for OPB
  input  logic [OPERAND_WIDTH-1:0]  OPA,
  input  logic [OPERAND_WIDTH-1:0]  OPB,
  output logic [OPERAND_WIDTH:0]    RES,
  output logic                      COUT,
  output logic                      OFLOW,
  output logic                      G,
  output logic                      E,
  output logic                      L,
  output logic                      ERR,
  output logic                      RES_VALID    // One cycle after the issue
);

  alu_op_if  #(.OPERAND_WIDTH(OPERAND_WIDTH)) op_if ();     // Issued operation
  alu_res_if #(.OPERAND_WIDTH(OPERAND_WIDTH)) arith_if ();  // Arithmetic result
  alu_res_if #(.OPERAND_WIDTH(OPERAND_WIDTH)) logic_if ();  // Logic result

  operand_capture #(
    .OPERAND_WIDTH (OPERAND_WIDTH),
    .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
  ) u_capture (
    .CLK      (CLK),
    .RST      (RST),
    .ce       (CE),
    .inp_valid(INP_VALID),
    .mode     (MODE),
    .cmd      (CMD),
    .cin      (CIN),
    .opa      (OPA),
    .opb      (OPB),
    .op       (op_if.source)
  );

  arith_unit #(.OPERAND_WIDTH(OPERAND_WIDTH)) u_arith (
    .op (op_if.sink),
    .res(arith_if.source)
  );

  logic_unit #(.OPERAND_WIDTH(OPERAND_WIDTH)) u_logic (
    .op (op_if.sink),
    .res(logic_if.source)
  );

  result_stage #(.OPERAND_WIDTH(OPERAND_WIDTH)) u_result (
    .CLK      (CLK),
    .RST      (RST),
    .op       (op_if.monitor),
    .arith_res(arith_if.sink),
    .logic_res(logic_if.sink),
    .RES      (RES),
    .COUT     (COUT),
    .OFLOW    (OFLOW),
    .G        (G),
    .E        (E),
    .L        (L),
    .ERR      (ERR),
    .RES_VALID(RES_VALID)
  );

endmodule

/* result_stage.sv */
`timescale 1ns/1ps

module result_stage #(
  parameter int OPERAND_WIDTH = 8
) (
  input  logic               CLK,
  input  logic               RST,
  alu_op_if.monitor          op,
  alu_res_if.sink            arith_res,
  alu_res_if.sink            logic_res,
  output logic [OPERAND_WIDTH:0] RES,
  output logic               COUT,
  output logic               OFLOW,
  output logic               G,
  output logic               E,
  output logic               L,
  output logic               ERR,
  output logic               RES_VALID
);
  import alu_pkg::*;

  logic use_arith;                           // MODE picks the unit

  assign use_arith = op.mode == MODE_ARITH;

  always_ff @(posedge CLK) begin
    if (RST) begin
      RES       <= '0;
      COUT      <= 1'b0;
      OFLOW     <= 1'b0;
      G         <= 1'b0;
      E         <= 1'b0;
      L         <= 1'b0;
      ERR       <= 1'b0;
      RES_VALID <= 1'b0;
    end else begin
      RES_VALID <= op.issue;                 // One pulse per issue
      if (op.issue) begin
        if (op.timeout) begin                // Dropped operand, error only
          RES   <= '0;
          COUT  <= 1'b0;
          OFLOW <= 1'b0;
          G     <= 1'b0;
          E     <= 1'b0;
          L     <= 1'b0;
          ERR   <= 1'b1;
        end else if (use_arith) begin
          RES   <= arith_res.res;
          COUT  <= arith_res.cout;
          OFLOW <= arith_res.oflow;
          G     <= arith_res.g;
          E     <= arith_res.e;
          L     <= arith_res.l;
          ERR   <= arith_res.err;
        end else begin
          RES   <= logic_res.res;
          COUT  <= logic_res.cout;
          OFLOW <= logic_res.oflow;
          G     <= logic_res.g;
          E     <= logic_res.e;
          L     <= logic_res.l;
          ERR   <= logic_res.err;
        end
      end                                    // Outputs hold between results
    end
  end

endmodule

/* logic_unit.sv */
`timescale 1ns/1ps

module logic_unit #(
  parameter int OPERAND_WIDTH = 8
) (
  alu_op_if.sink   op,
  alu_res_if.source res
);
  import alu_pkg::*;

  localparam int W    = OPERAND_WIDTH;
  localparam int SH_W = $clog2(OPERAND_WIDTH);  // Rotate amount bits

  logic [SH_W-1:0] rot_amt;                  // Low bits of B
  logic            rot_bad;                  // Higher bits of B set
  logic [2*W-1:0]  rol_d;                    // Doubled A, shifted
  logic [2*W-1:0]  ror_d;
  logic [W-1:0]    val;                      // Result before zero extension
  logic            bad_cmd;

  assign rot_amt = op.opb[SH_W-1:0];
  assign rot_bad = |op.opb[W-1:SH_W];
  assign rol_d   = {op.opa, op.opa} << rot_amt;
  assign ror_d   = {op.opa, op.opa} >> rot_amt;

  always_comb begin
    val     = '0;
    bad_cmd = 1'b0;
    case (op.cmd.l_cmd)
      AND:     val = op.opa & op.opb;
      NAND:    val = ~(op.opa & op.opb);
      OR:      val = op.opa | op.opb;
      NOR:     val = ~(op.opa | op.opb);
      XOR:     val = op.opa ^ op.opb;
      XNOR:    val = ~(op.opa ^ op.opb);
      NOT_A:   val = ~op.opa;
      NOT_B:   val = ~op.opb;
      SHR_A:   val = op.opa >> 1;            // MSB filled with 0
      SHL_A:   val = op.opa << 1;            // Shifted-out bit is lost
      SHR_B:   val = op.opb >> 1;
      SHL_B:   val = op.opb << 1;
      ROL:     val = rol_d[2*W-1:W];         // Upper half holds the wrap
      ROR:     val = ror_d[W-1:0];
      default: bad_cmd = 1'b1;               // Codes 14 and 15
    endcase
  end

  assign res.res = {1'b0, val};              // Bit W is never set here

  // Rotates still produce a result when the amount is out of range
  assign res.err = bad_cmd |
                   (rot_bad & ((op.cmd.l_cmd == ROL) | (op.cmd.l_cmd == ROR)));

  assign res.cout  = 1'b0;                   // No arithmetic flags in logic mode
  assign res.oflow = 1'b0;
  assign res.g     = 1'b0;
  assign res.e     = 1'b0;
  assign res.l     = 1'b0;

endmodule

/* arith_unit.sv */
`timescale 1ns/1ps

module arith_unit #(
  parameter int OPERAND_WIDTH = 8
) (
  alu_op_if.sink   op,
  alu_res_if.source res
);
  import alu_pkg::*;

  localparam int W = OPERAND_WIDTH;

  logic [W:0] ext_a;                         // Zero-extended operands
  logic [W:0] ext_b;
  logic [W:0] sext_a;                        // Sign-extended operands
  logic [W:0] sext_b;
  logic [W:0] add_r;
  logic [W:0] adc_r;
  logic [W:0] sub_r;
  logic [W:0] sbb_r;
  logic [W:0] sadd_r;
  logic [W:0] ssub_r;
  logic       lt_u;                          // Unsigned A < B
  logic       lt_s;                          // Signed A < B
  logic       eq;

  assign ext_a  = {1'b0, op.opa};
  assign ext_b  = {1'b0, op.opb};
  assign sext_a = {op.opa[W-1], op.opa};
  assign sext_b = {op.opb[W-1], op.opb};

  assign add_r  = ext_a + ext_b;
  assign adc_r  = add_r + op.cin;            // Max value still fits W+1 bits
  assign sub_r  = ext_a - ext_b;
  assign sbb_r  = sub_r - op.cin;
  assign sadd_r = sext_a + sext_b;           // Full signed result in W+1 bits
  assign ssub_r = sext_a - sext_b;

  assign lt_u = op.opa < op.opb;
  assign lt_s = $signed(op.opa) < $signed(op.opb);
  assign eq   = op.opa == op.opb;

  always_comb begin
    res.res   = '0;                          // Unused outputs stay at zero
    res.cout  = 1'b0;
    res.oflow = 1'b0;
    res.g     = 1'b0;
    res.e     = 1'b0;
    res.l     = 1'b0;
    res.err   = 1'b0;
    case (op.cmd.a_cmd)
      ADD: begin
        res.res  = add_r;
        res.cout = add_r[W];
      end
      SUB: begin
        res.res   = sub_r;
        res.oflow = lt_u;                    // Unsigned borrow
      end
      ADC: begin
        res.res  = adc_r;
        res.cout = adc_r[W];
      end
      SBB: begin
        res.res   = sbb_r;
        res.oflow = lt_u | (eq & op.cin);    // Borrow through carry in
      end
      INC_A: begin
        res.res  = ext_a + 1'b1;
        res.cout = &op.opa;                  // Same as bit W of the sum
      end
      DEC_A: begin
        res.res   = ext_a - 1'b1;
        res.oflow = ~|op.opa;                // Borrow only from zero
      end
      INC_B: begin
        res.res  = ext_b + 1'b1;
        res.cout = &op.opb;
      end
      DEC_B: begin
        res.res   = ext_b - 1'b1;
        res.oflow = ~|op.opb;
      end
      CMP: begin                             // Flags only, RES stays 0
        res.e = eq;
        res.g = ~eq & ~lt_u;
        res.l = lt_u;
      end
      SADD: begin
        res.res   = sadd_r;
        res.cout  = sadd_r[W];
        res.oflow = sadd_r[W] ^ sadd_r[W-1]; // Sign bits split on overflow
        res.e     = eq;
        res.g     = ~eq & ~lt_s;
        res.l     = lt_s;
      end
      SSUB: begin
        res.res   = ssub_r;
        res.oflow = ssub_r[W] ^ ssub_r[W-1];
        res.e     = eq;
        res.g     = ~eq & ~lt_s;
        res.l     = lt_s;
      end
      default: res.err = 1'b1;               // Codes 9, 10, 13 to 15
    endcase
  end

endmodule

/* operand_capture.sv */
`timescale 1ns/1ps

module operand_capture #(
  parameter int OPERAND_WIDTH  = 8,
  parameter int TIMEOUT_CYCLES = 16
) (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      ce,
  input  logic [1:0]                inp_valid,
  input  logic                      mode,
  input  logic [alu_pkg::CMD_W-1:0] cmd,
  input  logic                      cin,
  input  logic [OPERAND_WIDTH-1:0]  opa,
  input  logic [OPERAND_WIDTH-1:0]  opb,
  alu_op_if.source                  op
);
  import alu_pkg::*;

  localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TIMEOUT_CYCLES - 1);

  logic                     cap_a;           // Capture A this edge
  logic                     cap_b;           // Capture B this edge
  logic                     a_nxt;           // A held after this edge
  logic                     b_nxt;           // B held after this edge
  logic                     a_held;
  logic                     b_held;
  logic [CNT_W-1:0]         wait_cnt;        // Edges spent with one operand alone
  logic                     issue_q;
  logic                     timeout_q;
  logic [OPERAND_WIDTH-1:0] opa_q;
  logic [OPERAND_WIDTH-1:0] opb_q;
  alu_cmd_u                 cmd_q;
  logic                     mode_q;
  logic                     cin_q;

  assign cap_a = ce & inp_valid[0];          // CE low hides all inputs
  assign cap_b = ce & inp_valid[1];
  assign a_nxt = a_held | cap_a;
  assign b_nxt = b_held | cap_b;

  // Held flags, wait window and issue strobe
  always_ff @(posedge CLK) begin
    if (RST) begin
      a_held    <= 1'b0;
      b_held    <= 1'b0;
      wait_cnt  <= '0;
      issue_q   <= 1'b0;
      timeout_q <= 1'b0;
    end else begin
      issue_q   <= 1'b0;                     // Strobe lasts one cycle
      timeout_q <= 1'b0;
      if (a_nxt && b_nxt) begin              // Pair complete, issue now
        issue_q  <= 1'b1;
        a_held   <= 1'b0;
        b_held   <= 1'b0;
        wait_cnt <= '0;
      end else if (cap_a || cap_b) begin     // New or overwritten lone operand
        a_held   <= a_nxt;
        b_held   <= b_nxt;
        wait_cnt <= '0;                      // Window restarts
      end else if (a_held ^ b_held) begin    // Waiting, counter runs even with CE low
        if (wait_cnt == CNT_LAST) begin      // Window used up
          issue_q   <= 1'b1;
          timeout_q <= 1'b1;
          a_held    <= 1'b0;                 // Pending operand dropped
          b_held    <= 1'b0;
          wait_cnt  <= '0;
        end else begin
          wait_cnt <= wait_cnt + 1'b1;
        end
      end
    end
  end

  // Operand and command payload
  always_ff @(posedge CLK) begin
    if (cap_a) opa_q <= opa;
    if (cap_b) opb_q <= opb;
    if (cap_a || cap_b) begin                // Any capture takes CMD, MODE, CIN
      cmd_q  <= cmd;
      mode_q <= mode;
      cin_q  <= cin;
    end
  end

  assign op.issue   = issue_q;
  assign op.timeout = timeout_q;
  assign op.mode    = mode_q;
  assign op.cmd     = cmd_q;
  assign op.opa     = opa_q;
  assign op.opb     = opb_q;
  assign op.cin     = cin_q;

endmodule

/* alu_res_if.sv */
`timescale 1ns/1ps

// Unregistered result of one execution unit
interface alu_res_if #(
  parameter int OPERAND_WIDTH = 8
);

  logic [OPERAND_WIDTH:0] res;               // One bit wider than an operand
  logic                   cout;              // Carry out
  logic                   oflow;             // Borrow or signed overflow
  logic                   g;                 // Compare greater
  logic                   e;                 // Compare equal
  logic                   l;                 // Compare less
  logic                   err;               // Bad command or rotate amount

  // Execution unit side
  modport source (output res, cout, oflow, g, e, l, err);

  // Result stage side
  modport sink (input res, cout, oflow, g, e, l, err);

endinterface

/* alu_op_if.sv */
`timescale 1ns/1ps

// Issued operation from capture to the execution units and result stage
interface alu_op_if #(
  parameter int OPERAND_WIDTH = 8
);
  import alu_pkg::*;

  logic                     issue;           // One-cycle strobe per operation
  logic                     timeout;         // Issue is a timeout error
  logic                     mode;            // High for arithmetic
  alu_cmd_u                 cmd;             // Captured command word
  logic [OPERAND_WIDTH-1:0] opa;             // Held operand A
  logic [OPERAND_WIDTH-1:0] opb;             // Held operand B
  logic                     cin;             // Captured carry in

  // Capture side drives everything
  modport source (output issue, timeout, mode, cmd, opa, opb, cin);

  // Execution units only see the operation payload
  modport sink (input cmd, opa, opb, cin);

  // Result stage needs the strobe and selection
  modport monitor (input issue, timeout, mode);

endinterface

/* alu_pkg.sv */
package alu_pkg;

  localparam int CMD_W = 4;                  // Command word width, fixed by the union

  localparam logic MODE_ARITH = 1'b1;        // MODE value that selects the arithmetic unit

  // Arithmetic command codes, read when MODE is high
  typedef enum logic [CMD_W-1:0] {
    ADD   = 4'd0,                            // A + B
    SUB   = 4'd1,                            // A - B
    ADC   = 4'd2,                            // A + B + CIN
    SBB   = 4'd3,                            // A - B - CIN
    INC_A = 4'd4,                            // A + 1
    DEC_A = 4'd5,                            // A - 1
    INC_B = 4'd6,                            // B + 1
    DEC_B = 4'd7,                            // B - 1
    CMP   = 4'd8,                            // Unsigned compare, no result word
    SADD  = 4'd11,                           // Signed add with signed compare
    SSUB  = 4'd12                            // Signed subtract with signed compare
  } arith_cmd_e;

  // Logic command codes, read when MODE is low
  typedef enum logic [CMD_W-1:0] {
    AND   = 4'd0,                            // Bitwise ops on A and B
    NAND  = 4'd1,
    OR    = 4'd2,
    NOR   = 4'd3,
    XOR   = 4'd4,
    XNOR  = 4'd5,
    NOT_A = 4'd6,                            // Single operand inversions
    NOT_B = 4'd7,
    SHR_A = 4'd8,                            // One-bit shifts, zero fill
    SHL_A = 4'd9,
    SHR_B = 4'd10,
    SHL_B = 4'd11,
    ROL   = 4'd12,                           // Rotate A by low bits of B
    ROR   = 4'd13
  } logic_cmd_e;

  // One CMD word, two decodings picked by MODE
  typedef union packed {
    arith_cmd_e a_cmd;                       // Arithmetic view
    logic_cmd_e l_cmd;                       // Logic view
  } alu_cmd_u;

endpackage
